// File: rv_pkg.sv
/* Core-wide widths, opcodes, FSM state codes, ALU operation enum and the
   instruction word with its R/I/S/B/U/J format views */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Control FSM encodings
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_FETCH      = 3'd0;
    localparam logic [STATE_W-1:0] ST_FETCH_WAIT = 3'd1;
    localparam logic [STATE_W-1:0] ST_EXECUTE    = 3'd2;
    localparam logic [STATE_W-1:0] ST_MEM_REQ    = 3'd3;
    localparam logic [STATE_W-1:0] ST_MEM_WAIT   = 3'd4;
    localparam logic [STATE_W-1:0] ST_COMMIT     = 3'd5;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_t;

endpackage

// File: rv_decoder.sv
/* Instruction decoder: register indices, immediate, ALU operation and class flags */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::rv_inst_t               inst,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rd_addr,
    output logic [rv_pkg::XLEN-1:0]        imm,
    output rv_pkg::alu_op_t                alu_op,
    output logic [2:0]                     funct3,
    output logic                           is_load,
    output logic                           is_store,
    output logic                           is_branch,
    output logic                           is_jal,
    output logic                           is_jalr,
    output logic                           is_lui,
    output logic                           is_auipc,
    output logic                           uses_imm,
    output logic                           writes_rd
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       is_op_imm;
    logic       is_op_reg;

    assign opcode  = inst.r.opcode;
    assign rs1     = inst.r.rs1;
    assign rs2     = inst.r.rs2;
    assign rd_addr = inst.r.rd;
    assign funct3  = inst.r.funct3;

    assign is_lui    = opcode == OP_LUI;
    assign is_auipc  = opcode == OP_AUIPC;
    assign is_jal    = opcode == OP_JAL;
    assign is_jalr   = opcode == OP_JALR;
    assign is_branch = opcode == OP_BRANCH;
    assign is_load   = opcode == OP_LOAD;
    assign is_store  = opcode == OP_STORE;
    assign is_op_imm = opcode == OP_IMM;
    assign is_op_reg = opcode == OP_REG;

    // ALU second operand from the immediate; address forms handled in execute
    assign uses_imm = is_op_imm | is_jalr | is_lui | is_auipc;

    // Unknown opcodes fall through as no-ops, x0 is never written
    assign writes_rd = (is_lui | is_auipc | is_jal | is_jalr | is_load |
                        is_op_imm | is_op_reg) && (rd_addr != '0);

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            OP_STORE:
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            OP_BRANCH:
                imm = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                       inst.b.imm_4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {inst.u.imm_31_12, 12'h000};
            OP_JAL:
                imm = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                       inst.j.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD; // Address and upper-immediate forms add
        if (is_op_imm || is_op_reg) begin
            case (inst.r.funct3)
                3'b000: alu_op = (is_op_reg && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL; // Bit 30
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// File: rv_execute.sv
/* Execute unit: operand select, ALU, branch compare and next-PC selection */
`timescale 1ns/1ps

module rv_execute (
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] rdata1,
    input  logic [rv_pkg::XLEN-1:0] rdata2,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [2:0]              funct3,
    input  logic                    is_branch,
    input  logic                    is_jal,
    input  logic                    is_jalr,
    input  logic                    is_lui,
    input  logic                    is_auipc,
    input  logic                    is_load,
    input  logic                    is_store,
    input  logic                    uses_imm,
    output logic [rv_pkg::XLEN-1:0] alu_result,
    output logic [rv_pkg::XLEN-1:0] next_pc,
    output logic [rv_pkg::XLEN-1:0] link_value
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            taken;

    assign op_a  = is_lui ? '0 : (is_auipc ? pc : rdata1);
    assign op_b  = (uses_imm || is_load || is_store) ? imm : rdata2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Branches compare the raw register values
    always_comb begin
        case (funct3)
            3'b000:  taken = rdata1 == rdata2;
            3'b001:  taken = rdata1 != rdata2;
            3'b100:  taken = $signed(rdata1) < $signed(rdata2);
            3'b101:  taken = $signed(rdata1) >= $signed(rdata2);
            3'b110:  taken = rdata1 < rdata2;
            3'b111:  taken = rdata1 >= rdata2;
            default: taken = 1'b0;
        endcase
    end

    assign link_value = pc + 32'd4;

    always_comb begin
        if (is_jal || (is_branch && taken))
            next_pc = pc + imm;
        else if (is_jalr)
            next_pc = {alu_result[XLEN-1:1], 1'b0}; // rs1 + imm, bit 0 dropped
        else
            next_pc = link_value;
    end

endmodule

// File: rv_regfile.sv
/* Register file, 31 writable registers with x0 hardwired to zero */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]       wdata,
    output logic [rv_pkg::XLEN-1:0]       rdata1,
    output logic [rv_pkg::XLEN-1:0]       rdata2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 1; k < 2**REG_ADDR_W; k++)
                regs[k] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rv_load_store.sv
/* Load/store lane logic: store alignment and strobes, load extraction and extension */
`timescale 1ns/1ps

module rv_load_store (
    input  logic [rv_pkg::XLEN-1:0] addr,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::XLEN-1:0] store_src,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
    output logic [rv_pkg::XLEN-1:0] dmem_addr,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]              dmem_wstrb,
    output logic [rv_pkg::XLEN-1:0] load_data
);
    logic [31:0] lane;

    assign dmem_addr = {addr[31:2], 2'b00}; // Word-aligned bus address

    // Source replicated over all lanes, strobes pick the live ones
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                dmem_wdata = {4{store_src[7:0]}};
                dmem_wstrb = 4'b0001 << addr[1:0];
            end
            2'b01: begin
                dmem_wdata = {2{store_src[15:0]}};
                dmem_wstrb = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                dmem_wdata = store_src;
                dmem_wstrb = 4'b1111;
            end
        endcase
    end

    assign lane = dmem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};   // LB
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]}; // LH
            3'b100:  load_data = {24'h0, lane[7:0]};           // LBU
            3'b101:  load_data = {16'h0, lane[15:0]};          // LHU
            default: load_data = lane;
        endcase
    end

endmodule

// File: rv_control.sv
/* Control FSM with PC, instruction, result and next-PC registers and all handshakes */
`timescale 1ns/1ps

module rv_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_req_ready,
    input  logic                          imem_resp_valid,
    input  logic [rv_pkg::XLEN-1:0]       imem_rdata,
    input  logic                          dmem_req_ready,
    input  logic                          dmem_resp_valid,
    input  logic                          commit_ready,
    input  logic [rv_pkg::XLEN-1:0]       alu_result,
    input  logic [rv_pkg::XLEN-1:0]       next_pc,
    input  logic [rv_pkg::XLEN-1:0]       link_value,
    input  logic [rv_pkg::XLEN-1:0]       load_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr,
    input  logic                          writes_rd,
    input  logic                          is_load,
    input  logic                          is_store,
    input  logic                          is_jal,
    input  logic                          is_jalr,
    output rv_pkg::rv_inst_t              inst,
    output logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          imem_req_valid,
    output logic [rv_pkg::XLEN-1:0]       imem_addr,
    output logic                          dmem_req_valid,
    output logic                          dmem_we,
    output logic                          commit_valid,
    output logic [rv_pkg::XLEN-1:0]       commit_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [rv_pkg::XLEN-1:0]       commit_wdata,
    output logic                          rf_we
);
    import rv_pkg::*;

    logic [STATE_W-1:0] state;
    logic [XLEN-1:0]    npc;    // Target saved in EXECUTE
    logic [XLEN-1:0]    result; // Value written back at commit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_FETCH:      if (imem_req_ready) state <= ST_FETCH_WAIT;
                ST_FETCH_WAIT: if (imem_resp_valid) state <= ST_EXECUTE;
                ST_EXECUTE:    state <= (is_load || is_store) ? ST_MEM_REQ : ST_COMMIT;
                ST_MEM_REQ:    if (dmem_req_ready) state <= ST_MEM_WAIT;
                ST_MEM_WAIT:   if (dmem_resp_valid) state <= ST_COMMIT;
                ST_COMMIT: begin
                    if (commit_ready) begin
                        state <= ST_FETCH;
                        pc    <= npc; // Retire and move on
                    end
                end
                default:       state <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH_WAIT && imem_resp_valid)
            inst <= imem_rdata;
        if (state == ST_EXECUTE) begin
            npc    <= next_pc;
            result <= (is_jal || is_jalr) ? link_value : alu_result;
        end
        if (state == ST_MEM_WAIT && dmem_resp_valid && is_load)
            result <= load_data;
    end

    assign imem_req_valid = state == ST_FETCH;
    assign imem_addr      = pc;
    assign dmem_req_valid = state == ST_MEM_REQ;
    assign dmem_we        = is_store;

    // Commit fields come from registers, so they hold under back-pressure
    assign commit_valid = state == ST_COMMIT;
    assign commit_pc    = pc;
    assign commit_rd    = writes_rd ? rd_addr : '0;
    assign commit_wdata = result;
    assign rf_we        = commit_valid && commit_ready && writes_rd;

endmodule

// File: rv_core.sv
/* Core top level, control FSM wired to decoder, register file, execute and load/store */
`timescale 1ns/1ps

module rv_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_req_ready,
    input  logic                          imem_resp_valid,
    input  logic [rv_pkg::XLEN-1:0]       imem_rdata,
    input  logic                          dmem_req_ready,
    input  logic                          dmem_resp_valid,
    input  logic [rv_pkg::XLEN-1:0]       dmem_rdata,
    input  logic                          commit_ready,
    output logic                          imem_req_valid,
    output logic [rv_pkg::XLEN-1:0]       imem_addr,
    output logic                          dmem_req_valid,
    output logic                          dmem_we,
    output logic [rv_pkg::XLEN-1:0]       dmem_addr,
    output logic [rv_pkg::XLEN-1:0]       dmem_wdata,
    output logic [3:0]                    dmem_wstrb,
    output logic                          commit_valid,
    output logic [rv_pkg::XLEN-1:0]       commit_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [rv_pkg::XLEN-1:0]       commit_wdata
);
    import rv_pkg::*;

    rv_inst_t              inst;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       pc, imm, rdata1, rdata2;
    logic [XLEN-1:0]       alu_result, next_pc, link_value, load_data;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd_addr;
    logic [2:0]            funct3;
    logic                  is_load, is_store, is_branch, is_jal, is_jalr;
    logic                  is_lui, is_auipc, uses_imm, writes_rd, rf_we;

    rv_control i_rv_control (
        .clk, .reset,
        .imem_req_ready, .imem_resp_valid, .imem_rdata,
        .dmem_req_ready, .dmem_resp_valid, .commit_ready,
        .alu_result, .next_pc, .link_value, .load_data,
        .rd_addr, .writes_rd, .is_load, .is_store, .is_jal, .is_jalr,
        .inst, .pc, .imem_req_valid, .imem_addr, .dmem_req_valid, .dmem_we,
        .commit_valid, .commit_pc, .commit_rd, .commit_wdata, .rf_we
    );

    rv_decoder i_rv_decoder (
        .inst, .rs1, .rs2, .rd_addr, .imm, .alu_op, .funct3,
        .is_load, .is_store, .is_branch, .is_jal, .is_jalr,
        .is_lui, .is_auipc, .uses_imm, .writes_rd
    );

    rv_regfile i_rv_regfile (
        .clk, .reset, .rs1, .rs2,
        .we    (rf_we),
        .waddr (rd_addr),
        .wdata (commit_wdata),
        .rdata1, .rdata2
    );

    rv_execute i_rv_execute (
        .pc, .rdata1, .rdata2, .imm, .alu_op, .funct3,
        .is_branch, .is_jal, .is_jalr, .is_lui, .is_auipc,
        .is_load, .is_store, .uses_imm,
        .alu_result, .next_pc, .link_value
    );

    rv_load_store i_rv_load_store (
        .addr      (alu_result),
        .funct3,
        .store_src (rdata2),
        .dmem_rdata, .dmem_addr, .dmem_wdata, .dmem_wstrb, .load_data
    );

endmodule

// File: rv_ref_model.svh
/* Reference model of the core with registers, PC and data bytes,
   plus the commit step task and the store expectation task */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [31:0] m_regs [32];
logic [31:0] m_pc;
logic [7:0]  m_data [256]; // Data bytes by low address byte

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt)
                return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] addr);
    logic [31:0] w;
    w = {m_data[8'(addr + 3)], m_data[8'(addr + 2)], m_data[8'(addr + 1)], m_data[addr[7:0]]};
    case (f3)
        3'd0:    return {{24{w[7]}}, w[7:0]};
        3'd1:    return {{16{w[15]}}, w[15:0]};
        3'd4:    return {24'h0, w[7:0]};
        3'd5:    return {16'h0, w[15:0]};
        default: return w;
    endcase
endfunction

// Retires one instruction and reports rd_out as zero when nothing is written
task automatic step_model(input logic [31:0] inst, output logic [4:0] rd_out,
                          output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] npc;
    logic [2:0]  f3;
    a      = m_regs[inst[19:15]];
    b      = m_regs[inst[24:20]];
    f3     = inst[14:12];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    npc    = m_pc + 32'd4;
    val    = '0;
    rd_out = inst[11:7];
    case (inst[6:0])
        OP_LUI:   val = {inst[31:12], 12'h000};
        OP_AUIPC: val = m_pc + {inst[31:12], 12'h000};
        OP_JAL: begin
            val = m_pc + 32'd4;
            npc = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OP_JALR: begin
            val = m_pc + 32'd4;
            npc = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            rd_out = '0;
            if (branch_ref(f3, a, b))
                npc = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        OP_LOAD:  val = load_ref(f3, a + imm_i);
        OP_STORE: begin
            rd_out = '0;
            for (int k = 0; k < (1 << f3[1:0]); k++)
                m_data[8'(a + {{20{inst[31]}}, inst[31:25], inst[11:7]} + k)] = b[8*k +: 8];
        end
        OP_IMM:   val = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
        OP_REG:   val = alu_ref(f3, inst[30], a, b);
        default:  rd_out = '0; // Unknown opcode retires as a no-op
    endcase
    if (rd_out != '0)
        m_regs[rd_out] = val;
    m_pc = npc;
endtask

// Bus view of a store with word address, byte strobes and data in its lanes
task automatic expect_store(input logic [31:0] inst, output logic [31:0] word_addr,
                            output logic [3:0] strb, output logic [31:0] data);
    logic [31:0] addr;
    addr      = m_regs[inst[19:15]] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
    word_addr = {addr[31:2], 2'b00};
    case (inst[13:12])
        2'd0:    strb = 4'b0001 << addr[1:0];
        2'd1:    strb = 4'b0011 << addr[1:0];
        default: strb = 4'b1111;
    endcase
    data = m_regs[inst[24:20]] << (8 * addr[1:0]);
endtask

`endif

// File: tb_rv_core.sv
/* Testbench for the core: random program, memory responders with random stalls,
   commit checker against the reference model */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int MAX_COMMITS    = 2000;
    localparam int TIMEOUT_CYCLES = MAX_COMMITS * 60;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  imem_req_ready, imem_resp_valid, imem_req_valid;
    logic                  dmem_req_ready, dmem_resp_valid, dmem_req_valid, dmem_we;
    logic                  commit_ready, commit_valid;
    logic [XLEN-1:0]       imem_rdata, imem_addr, dmem_rdata, dmem_addr, dmem_wdata;
    logic [XLEN-1:0]       commit_pc, commit_wdata;
    logic [3:0]            dmem_wstrb;
    logic [REG_ADDR_W-1:0] commit_rd;

    logic [31:0] prog [256];       // Program at RESET_PC, indexed by pc[9:2]
    logic [31:0] dmem_words [64];  // Data memory seen by the DUT
    logic        i_pend, d_pend, held;
    int          i_wait, d_wait, cycles, commits;
    logic [31:0] i_word, d_word, held_pc, held_wdata;
    logic [4:0]  held_rd;

    `include "rv_ref_model.svh"

    rv_core i_rv_core (.*);

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic [11:0] mem_offset(input logic [1:0] size);
        logic [11:0] off;
        off = 12'($urandom % 256) - 12'd128; // x1 sits mid-array
        if (size != 2'd0)
            off[0] = 1'b0;
        if (size == 2'd2)
            off[1] = 1'b0;
        return off;
    endfunction

    function automatic logic [31:0] gen_inst(input int idx);
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] off;
        rd    = 5'($urandom);
        if (rd == 5'd1 || rd == 5'd2)
            rd = 5'd0; // x1 and x2 keep the data and code bases
        rs1   = 5'($urandom);
        rs2   = 5'($urandom);
        f3    = 3'($urandom);
        f7    = ($urandom % 2) ? 7'h20 : 7'h00;
        imm12 = 12'($urandom);
        off   = 32'((int'($urandom % 256) - idx) * 4); // Target inside the program
        case ($urandom % 10)
            0, 1: begin
                if (f3 != 3'd0 && f3 != 3'd5)
                    f7 = 7'h00;
                return {f7, rs2, rs1, f3, rd, OP_REG};
            end
            2, 3: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm12 = {(f3 == 3'd5) ? f7 : 7'h00, rs2}; // Shift amount
                return {imm12, rs1, f3, rd, OP_IMM};
            end
            4: return {20'($urandom), rd, f3[0] ? OP_LUI : OP_AUIPC};
            5: begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 + 3'd2;
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
            end
            6: return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
            7: return {2'b00, 8'($urandom), 2'b00, 5'd2, 3'd0, rd, OP_JALR};
            8: begin
                if (f3 == 3'd3 || f3 >= 3'd6)
                    f3 = f3 & 3'b101;
                imm12 = mem_offset(f3[1:0]);
                return {imm12, 5'd1, f3, rd, OP_LOAD};
            end
            default: begin
                f3    = f3[1] ? 3'd2 : {2'b00, f3[0]};
                imm12 = mem_offset(f3[1:0]);
                return {imm12[11:5], rs2, 5'd1, f3, imm12[4:0], OP_STORE};
            end
        endcase
    endfunction

    // Looks at the handshakes that complete on this rising edge
    task automatic sample_handshakes();
        logic [31:0] wa, wd, mask, inst, exp_val;
        logic [3:0]  ws;
        logic [4:0]  exp_rd;
        if (held) begin
            assert (commit_valid && commit_pc == held_pc && commit_rd == held_rd &&
                    commit_wdata == held_wdata)
            else abort_run($sformatf("MISMATCH at %0t: commit outputs moved while stalled", $time));
        end
        held       = commit_valid && !commit_ready;
        held_pc    = commit_pc;
        held_rd    = commit_rd;
        held_wdata = commit_wdata;
        if (commit_valid && commit_ready) begin
            assert (commit_pc == m_pc)
            else abort_run($sformatf("MISMATCH at %0t: commit_pc %h, expected %h",
                                     $time, commit_pc, m_pc));
            step_model(prog[m_pc[9:2]], exp_rd, exp_val);
            assert (commit_rd == exp_rd)
            else abort_run($sformatf("MISMATCH at %0t: commit_rd %0d, expected %0d",
                                     $time, commit_rd, exp_rd));
            if (exp_rd != 5'd0) begin
                assert (commit_wdata == exp_val)
                else abort_run($sformatf("MISMATCH at %0t: x%0d written %h, expected %h",
                                         $time, exp_rd, commit_wdata, exp_val));
            end
            commits++;
        end
        if (imem_req_valid && imem_req_ready) begin
            assert (imem_addr == m_pc)
            else abort_run($sformatf("MISMATCH at %0t: fetch from %h, expected %h",
                                     $time, imem_addr, m_pc));
            i_pend = 1'b1;
            i_wait = $urandom % 4;
            i_word = prog[imem_addr[9:2]];
        end
        if (dmem_req_valid && dmem_req_ready) begin
            inst = prog[m_pc[9:2]];
            assert (dmem_we == (inst[6:0] == OP_STORE))
            else abort_run($sformatf("MISMATCH at %0t: dmem_we %b for %h", $time, dmem_we, inst));
            if (dmem_we) begin
                expect_store(inst, wa, ws, wd);
                mask = {{8{ws[3]}}, {8{ws[2]}}, {8{ws[1]}}, {8{ws[0]}}};
                assert (dmem_addr == wa && dmem_wstrb == ws && (dmem_wdata & mask) == (wd & mask))
                else abort_run($sformatf("MISMATCH at %0t: store %h/%b/%h, expected %h/%b/%h",
                                         $time, dmem_addr, dmem_wstrb, dmem_wdata, wa, ws, wd));
                for (int k = 0; k < 4; k++)
                    if (ws[k])
                        dmem_words[dmem_addr[7:2]][8*k +: 8] = dmem_wdata[8*k +: 8];
            end
            d_pend = 1'b1;
            d_wait = $urandom % 4;
            d_word = dmem_words[dmem_addr[7:2]];
        end
    endtask

    task automatic drive_inputs();
        imem_req_ready  = ($urandom % 3) != 0;
        dmem_req_ready  = ($urandom % 2) != 0;
        commit_ready    = ($urandom % 3) != 0; // Low about a third of the time
        imem_resp_valid = i_pend && i_wait == 0;
        imem_rdata      = i_word;
        if (imem_resp_valid)
            i_pend = 1'b0;
        else if (i_pend)
            i_wait--;
        dmem_resp_valid = d_pend && d_wait == 0;
        dmem_rdata      = d_word;
        if (dmem_resp_valid)
            d_pend = 1'b0;
        else if (d_pend)
            d_wait--;
    endtask

    initial begin
        void'($urandom(32'h435f));
        reset           = 1'b1;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_rdata      = '0;
        dmem_req_ready  = 1'b0;
        dmem_resp_valid = 1'b0;
        dmem_rdata      = '0;
        commit_ready    = 1'b0;
        i_pend  = 1'b0;
        d_pend  = 1'b0;
        held    = 1'b0;
        i_word  = '0;
        d_word  = '0;
        cycles  = 0;
        commits = 0;
        prog[0] = {12'h480, 5'd0, 3'd0, 5'd1, OP_IMM}; // x1 = data array + 128
        prog[1] = {20'h80000, 5'd2, OP_LUI};           // x2 = program base
        for (int i = 2; i < 256; i++)
            prog[i] = gen_inst(i);
        for (int i = 0; i < 256; i++) begin
            m_data[i] = 8'($urandom);
            dmem_words[i / 4][8 * (i % 4) +: 8] = m_data[i];
        end
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        m_pc = RESET_PC;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        while (commits < MAX_COMMITS) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run($sformatf("Timeout with %0d of %0d instructions retired",
                                    commits, MAX_COMMITS));
            sample_handshakes();
            #1;
            drive_inputs();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_execute.sv
rv_regfile.sv
rv_load_store.sv
rv_control.sv
rv_core.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_core \
    -o sim_rv_core && ./obj_dir/sim_rv_core 2>&1 | tee sim.log
grep -q "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
